// File: hw/noc_pkg.sv
////////////////////
// NoC package
// Coordinates, flit layout, router ports, host port and register map
// shared by the traffic generator tile
////////////////////

package noc_pkg;

  localparam int unsigned CoordWidth = 3;
  localparam int unsigned DataWidth  = 32;

  // Galois feedback mask, taps 32 30 26 25
  localparam logic [DataWidth-1:0] LfsrTaps = 32'hA300_0000;

  ////////////////////
  // Mesh types
  ////////////////////

  typedef struct packed {
    logic [CoordWidth-1:0] x;
    logic [CoordWidth-1:0] y;
  } id_t;

  typedef struct packed {
    id_t dst_id;
    id_t src_id;
  } hdr_t;

  typedef struct packed {
    hdr_t                 hdr;
    logic [DataWidth-1:0] payload;
  } flit_t;

  // Router port index, mesh directions first
  typedef enum logic [2:0] {
    North = 3'd0,
    East  = 3'd1,
    South = 3'd2,
    West  = 3'd3,
    Eject = 3'd4
  } port_e;

  // Generator request into the chimney
  typedef struct packed {
    id_t                  dst_id;
    logic [DataWidth-1:0] payload;
  } gen_req_t;

  ////////////////////
  // Host port
  ////////////////////

  typedef enum logic [2:0] {
    RegCtrl    = 3'd0,  // bit 0 starts a burst
    RegDst     = 3'd1,
    RegCount   = 3'd2,
    RegSeed    = 3'd3,
    RegSent    = 3'd4,  // read only from here on
    RegRxCount = 3'd5,
    RegRxXor   = 3'd6,
    RegStatus  = 3'd7
  } reg_addr_e;

  typedef struct packed {
    logic        we;
    reg_addr_e   addr;
    logic [31:0] wdata;
  } host_req_t;

  typedef enum logic {
    Idle = 1'b0,
    Run  = 1'b1
  } gen_state_e;

endpackage

// File: hw/noc_router.sv
////////////////////
// Five-port mesh router
// Input FIFOs, XY routing on the head flit, round-robin output arbiters
////////////////////

module noc_router #(
  parameter int unsigned InFifoDepth = 2
) (
  input  logic                                             clk_i,
  input  logic                                             rst_n_i,
  input  noc_pkg::id_t                                     id_i,
  input  noc_pkg::flit_t [noc_pkg::Eject:noc_pkg::North]   flit_i,
  input  logic           [noc_pkg::Eject:noc_pkg::North]   valid_i,
  output logic           [noc_pkg::Eject:noc_pkg::North]   ready_o,
  output noc_pkg::flit_t [noc_pkg::Eject:noc_pkg::North]   flit_o,
  output logic           [noc_pkg::Eject:noc_pkg::North]   valid_o,
  input  logic           [noc_pkg::Eject:noc_pkg::North]   ready_i
);
  import noc_pkg::*;

  localparam int unsigned NumPorts = 5;
  localparam int unsigned PtrWidth = (InFifoDepth > 1) ? $clog2(InFifoDepth) : 1;
  localparam int unsigned CntWidth = $clog2(InFifoDepth + 1);

  function automatic logic [PtrWidth-1:0] ptr_inc(logic [PtrWidth-1:0] ptr);
    return (ptr == PtrWidth'(InFifoDepth - 1)) ? '0 : ptr + 1'b1;
  endfunction

  // Dimension order, x first
  function automatic port_e xy_route(id_t dst, id_t own);
    port_e dir;
    if (dst.x > own.x) begin
      dir = East;
    end else if (dst.x < own.x) begin
      dir = West;
    end else if (dst.y > own.y) begin
      dir = North;
    end else if (dst.y < own.y) begin
      dir = South;
    end else begin
      dir = Eject;
    end
    return dir;
  endfunction

  function automatic logic [2:0] wrap_add(logic [2:0] base, int unsigned step);
    int unsigned sum;
    sum = base + step;
    return 3'(sum % NumPorts);
  endfunction

  ////////////////////
  // Input FIFOs
  ////////////////////

  flit_t               fifo_mem  [NumPorts][InFifoDepth];
  logic [PtrWidth-1:0] wr_ptr_q  [NumPorts];
  logic [PtrWidth-1:0] rd_ptr_q  [NumPorts];
  logic [CntWidth-1:0] count_q   [NumPorts];
  flit_t               head      [NumPorts];
  port_e               route     [NumPorts];
  logic [NumPorts-1:0] push;
  logic [NumPorts-1:0] pop;
  logic [NumPorts-1:0] not_empty;

  for (genvar i = 0; i < NumPorts; i++) begin : gen_input
    assign ready_o[i]   = (count_q[i] != CntWidth'(InFifoDepth));
    assign push[i]      = valid_i[i] & ready_o[i];
    assign not_empty[i] = (count_q[i] != '0);
    assign head[i]      = fifo_mem[i][rd_ptr_q[i]];
    assign route[i]     = xy_route(head[i].hdr.dst_id, id_i);

    always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
        wr_ptr_q[i] <= '0;
        rd_ptr_q[i] <= '0;
        count_q[i]  <= '0;
      end else begin
        if (push[i]) begin
          wr_ptr_q[i] <= ptr_inc(wr_ptr_q[i]);
        end
        if (pop[i]) begin
          rd_ptr_q[i] <= ptr_inc(rd_ptr_q[i]);
        end
        case ({push[i], pop[i]})
          2'b10:   count_q[i] <= count_q[i] + 1'b1;
          2'b01:   count_q[i] <= count_q[i] - 1'b1;
          default: count_q[i] <= count_q[i];
        endcase
      end
    end

    always_ff @(posedge clk_i) begin
      if (push[i]) begin
        fifo_mem[i][wr_ptr_q[i]] <= flit_i[i];
      end
    end
  end

  ////////////////////
  // Output arbiters
  ////////////////////

  logic [2:0]          rr_ptr_q [NumPorts];
  logic [2:0]          gnt_idx  [NumPorts];
  logic [NumPorts-1:0] gnt_valid;

  // First requester at or after the pointer wins
  always_comb begin
    logic [2:0] cand;
    cand      = '0;
    gnt_valid = '0;
    for (int o = 0; o < NumPorts; o++) begin
      gnt_idx[o] = rr_ptr_q[o];
      for (int k = 0; k < NumPorts; k++) begin
        cand = wrap_add(rr_ptr_q[o], k);
        if (!gnt_valid[o] && not_empty[cand] && (route[cand] == port_e'(o))) begin
          gnt_valid[o] = 1'b1;
          gnt_idx[o]   = cand;
        end
      end
    end
  end

  always_comb begin
    pop = '0;
    for (int o = 0; o < NumPorts; o++) begin
      if (gnt_valid[o] && ready_i[o]) begin
        pop[gnt_idx[o]] = 1'b1;
      end
    end
  end

  for (genvar o = 0; o < NumPorts; o++) begin : gen_output
    assign valid_o[o] = gnt_valid[o];
    assign flit_o[o]  = head[gnt_idx[o]];

    // A stalled winner keeps top priority so the offered flit stays put
    always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
        rr_ptr_q[o] <= '0;
      end else if (gnt_valid[o]) begin
        rr_ptr_q[o] <= ready_i[o] ? wrap_add(gnt_idx[o], 1) : gnt_idx[o];
      end
    end
  end

endmodule

// File: hw/noc_chimney.sv
////////////////////
// Network interface
// Packs generator requests into single-flit packets and
// counts and checksums the flits ejected at this tile
////////////////////

module noc_chimney (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  input  noc_pkg::id_t                  id_i,
  // Generator side
  input  noc_pkg::gen_req_t             gen_req_i,
  input  logic                          gen_valid_i,
  output logic                          gen_ready_o,
  // Injection into the router
  output noc_pkg::flit_t                inj_flit_o,
  output logic                          inj_valid_o,
  input  logic                          inj_ready_i,
  // Ejection from the router
  input  noc_pkg::flit_t                ej_flit_i,
  input  logic                          ej_valid_i,
  output logic                          ej_ready_o,
  // Receive statistics
  output logic [31:0]                   rx_count_o,
  output logic [noc_pkg::DataWidth-1:0] rx_xor_o
);
  import noc_pkg::*;

  ////////////////////
  // Injection
  ////////////////////

  hdr_t inj_hdr;

  assign inj_hdr.dst_id = gen_req_i.dst_id;
  assign inj_hdr.src_id = id_i;

  assign inj_flit_o.hdr     = inj_hdr;
  assign inj_flit_o.payload = gen_req_i.payload;
  assign inj_valid_o        = gen_valid_i;
  assign gen_ready_o        = inj_ready_i;

  ////////////////////
  // Ejection
  ////////////////////

  logic                 ej_xfer;
  logic [31:0]          rx_count_q;
  logic [DataWidth-1:0] rx_xor_q;

  // Sink never stalls
  assign ej_ready_o = 1'b1;
  assign ej_xfer    = ej_valid_i & ej_ready_o;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rx_count_q <= '0;
      rx_xor_q   <= '0;
    end else if (ej_xfer) begin
      rx_count_q <= rx_count_q + 1'b1;
      rx_xor_q   <= rx_xor_q ^ ej_flit_i.payload;
    end
  end

  assign rx_count_o = rx_count_q;
  assign rx_xor_o   = rx_xor_q;

endmodule

// File: hw/traffic_gen.sv
////////////////////
// Traffic generator
// Host register file on a four-phase port and an LFSR burst engine
////////////////////

module traffic_gen (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  // Host port
  input  noc_pkg::host_req_t            host_req_i,
  input  logic                          host_req_valid_i,
  output logic                          host_ack_o,
  output logic [31:0]                   host_rdata_o,
  // Request stream to the chimney
  output noc_pkg::gen_req_t             gen_req_o,
  output logic                          gen_valid_o,
  input  logic                          gen_ready_i,
  // Receive statistics
  input  logic [31:0]                   rx_count_i,
  input  logic [noc_pkg::DataWidth-1:0] rx_xor_i
);
  import noc_pkg::*;

  ////////////////////
  // Host handshake
  ////////////////////

  logic        ack_q;
  logic        req_new;
  logic        wr_en;
  logic        start;
  logic        busy;
  logic [31:0] rdata_q;

  // Ack follows req one cycle late
  assign req_new = host_req_valid_i & ~ack_q;
  assign wr_en   = req_new & host_req_i.we;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= host_req_valid_i;
    end
  end

  ////////////////////
  // Registers
  ////////////////////

  id_t                  dst_q;
  logic [31:0]          count_q;
  logic [DataWidth-1:0] seed_q;
  logic [31:0]          sent_q;
  logic [DataWidth-1:0] lfsr_q;
  gen_state_e           state_q;
  logic                 xfer;
  logic [31:0]          sent_next;

  assign busy  = (state_q == Run);
  assign start = wr_en && (host_req_i.addr == RegCtrl) && host_req_i.wdata[0] && !busy;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      dst_q   <= '0;
      count_q <= '0;
      seed_q  <= DataWidth'(1);
    end else if (wr_en) begin
      case (host_req_i.addr)
        RegDst:   dst_q   <= id_t'(host_req_i.wdata[$bits(id_t)-1:0]);
        RegCount: count_q <= host_req_i.wdata;
        RegSeed:  seed_q  <= host_req_i.wdata[DataWidth-1:0];
        default:  ;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_new) begin
      case (host_req_i.addr)
        RegDst:     rdata_q <= 32'(dst_q);
        RegCount:   rdata_q <= count_q;
        RegSeed:    rdata_q <= 32'(seed_q);
        RegSent:    rdata_q <= sent_q;
        RegRxCount: rdata_q <= rx_count_i;
        RegRxXor:   rdata_q <= 32'(rx_xor_i);
        RegStatus:  rdata_q <= {31'b0, busy};
        default:    rdata_q <= '0;
      endcase
    end
  end

  assign host_ack_o   = ack_q;
  assign host_rdata_o = rdata_q;

  ////////////////////
  // Burst engine
  ////////////////////

  assign gen_valid_o       = busy && (sent_q < count_q);
  assign gen_req_o.dst_id  = dst_q;
  assign gen_req_o.payload = lfsr_q;
  assign xfer              = gen_valid_o & gen_ready_i;
  assign sent_next         = sent_q + 32'(xfer);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= Idle;
      sent_q  <= '0;
    end else if (start) begin
      state_q <= Run;
      sent_q  <= '0;
    end else if (busy) begin
      sent_q <= sent_next;
      if (sent_next >= count_q) begin
        state_q <= Idle;
      end
    end
  end

  // One Galois step per accepted flit
  always_ff @(posedge clk_i) begin
    if (start) begin
      lfsr_q <= seed_q;
    end else if (xfer) begin
      lfsr_q <= (lfsr_q >> 1) ^ ({DataWidth{lfsr_q[0]}} & LfsrTaps);
    end
  end

endmodule

// File: hw/traffic_gen_tile.sv
////////////////////
// Traffic generator tile
// Router, chimney and generator of one mesh node
////////////////////

module traffic_gen_tile #(
  parameter int unsigned InFifoDepth = 2
) (
  input  logic                                           clk_i,
  input  logic                                           rst_n_i,
  input  noc_pkg::id_t                                   id_i,
  // Mesh links
  input  noc_pkg::flit_t [noc_pkg::West:noc_pkg::North]  flit_i,
  input  logic           [noc_pkg::West:noc_pkg::North]  valid_i,
  output logic           [noc_pkg::West:noc_pkg::North]  ready_o,
  output noc_pkg::flit_t [noc_pkg::West:noc_pkg::North]  flit_o,
  output logic           [noc_pkg::West:noc_pkg::North]  valid_o,
  input  logic           [noc_pkg::West:noc_pkg::North]  ready_i,
  // Host port
  input  noc_pkg::host_req_t                             host_req_i,
  input  logic                                           host_req_valid_i,
  output logic                                           host_ack_o,
  output logic [31:0]                                    host_rdata_o
);
  import noc_pkg::*;

  ////////////////////
  // Router
  ////////////////////

  flit_t [Eject:North] router_flit_in;
  flit_t [Eject:North] router_flit_out;
  logic  [Eject:North] router_valid_in;
  logic  [Eject:North] router_ready_out;
  logic  [Eject:North] router_valid_out;
  logic  [Eject:North] router_ready_in;

  noc_router #(
    .InFifoDepth(InFifoDepth)
  ) i_router (
    .clk_i,
    .rst_n_i,
    .id_i,
    .flit_i (router_flit_in),
    .valid_i(router_valid_in),
    .ready_o(router_ready_out),
    .flit_o (router_flit_out),
    .valid_o(router_valid_out),
    .ready_i(router_ready_in)
  );

  assign router_flit_in[West:North]  = flit_i;
  assign router_valid_in[West:North] = valid_i;
  assign ready_o                     = router_ready_out[West:North];
  assign flit_o                      = router_flit_out[West:North];
  assign valid_o                     = router_valid_out[West:North];
  assign router_ready_in[West:North] = ready_i;

  ////////////////////
  // Chimney and generator
  ////////////////////

  gen_req_t             gen_req;
  logic                 gen_valid;
  logic                 gen_ready;
  logic [31:0]          rx_count;
  logic [DataWidth-1:0] rx_xor;

  noc_chimney i_chimney (
    .clk_i,
    .rst_n_i,
    .id_i,
    .gen_req_i  (gen_req),
    .gen_valid_i(gen_valid),
    .gen_ready_o(gen_ready),
    .inj_flit_o (router_flit_in[Eject]),
    .inj_valid_o(router_valid_in[Eject]),
    .inj_ready_i(router_ready_out[Eject]),
    .ej_flit_i  (router_flit_out[Eject]),
    .ej_valid_i (router_valid_out[Eject]),
    .ej_ready_o (router_ready_in[Eject]),
    .rx_count_o (rx_count),
    .rx_xor_o   (rx_xor)
  );

  traffic_gen i_traffic_gen (
    .clk_i,
    .rst_n_i,
    .host_req_i,
    .host_req_valid_i,
    .host_ack_o,
    .host_rdata_o,
    .gen_req_o  (gen_req),
    .gen_valid_o(gen_valid),
    .gen_ready_i(gen_ready),
    .rx_count_i (rx_count),
    .rx_xor_i   (rx_xor)
  );

endmodule

// File: tb/tb_traffic_gen_tile.sv
////////////////////
// Traffic generator tile testbench
// Host driver, neighbour drivers and an XY and LFSR model
////////////////////

module tb_traffic_gen_tile;
  timeunit 1ns;
  timeprecision 1ps;
  import noc_pkg::*;

  localparam int  ClkPeriod    = 10;
  localparam int  BurstLen     = 32;
  localparam int  LocalFlits   = 40;
  localparam int  TransitFlits = 200;
  localparam int  MixFlits     = 60;
  localparam int  TotalFlits   = 2 * BurstLen + LocalFlits + TransitFlits + MixFlits;
  localparam int  LimitCycles  = TotalFlits * 40 + 1000;
  localparam id_t TileId       = '{x: 3'd3, y: 3'd3};

  logic               clk;
  logic               rst_n          = 1'b0;
  flit_t [West:North] in_flit        = '0;
  logic  [West:North] in_valid       = '0;
  logic  [West:North] in_ready;
  flit_t [West:North] out_flit;
  logic  [West:North] out_valid;
  logic  [West:North] out_ready      = '0;
  host_req_t          host_req       = '0;
  logic               host_req_valid = 1'b0;
  logic               host_ack;
  logic [31:0]        host_rdata;

  integer      seed           = 92;
  int          errors         = 0;
  int          flits_seen     = 0;
  logic [3:0]  take           = '0;
  flit_t       drv_q [4][$];
  // Indexed by source * 4 + output with the generator as source 4
  flit_t       exp_q [20][$];
  int unsigned rx_count_model = 0;
  logic [31:0] rx_xor_model   = '0;
  // Arbitration evidence on outputs shared by generator and neighbours
  int          gen_shared     = 0;
  int          nbr_shared     = 0;
  int          last_src [4];

  traffic_gen_tile #(
    .InFifoDepth(2)
  ) dut_i (
    .clk_i           (clk),
    .rst_n_i         (rst_n),
    .id_i            (TileId),
    .flit_i          (in_flit),
    .valid_i         (in_valid),
    .ready_o         (in_ready),
    .flit_o          (out_flit),
    .valid_o         (out_valid),
    .ready_i         (out_ready),
    .host_req_i      (host_req),
    .host_req_valid_i(host_req_valid),
    .host_ack_o      (host_ack),
    .host_rdata_o    (host_rdata)
  );

  initial begin
    clk = 1'b0;
    forever #(ClkPeriod / 2) clk = ~clk;
  end

  ////////////////////
  // Model
  ////////////////////

  function automatic port_e route_of(id_t dst);
    if (dst.x > TileId.x) return East;
    if (dst.x < TileId.x) return West;
    if (dst.y > TileId.y) return North;
    if (dst.y < TileId.y) return South;
    return Eject;
  endfunction

  function automatic logic [31:0] lfsr_step(logic [31:0] v);
    return v[0] ? ((v >> 1) ^ LfsrTaps) : (v >> 1);
  endfunction

  function automatic id_t rand_id();
    logic [5:0] r;
    r = 6'($random(seed));
    return id_t'(r);
  endfunction

  function automatic int pending();
    int n;
    n = 0;
    for (int p = 0; p < 4; p++) begin
      n += drv_q[p].size() + int'(in_valid[p]);
    end
    for (int q = 0; q < 20; q++) begin
      n += exp_q[q].size();
    end
    return n;
  endfunction

  task automatic check(string name, logic [31:0] got, logic [31:0] exp);
    if (got !== exp) begin
      errors++;
      $display("FAIL t=%0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  // Flit must be the oldest pending one of some source for this output
  task automatic match_output(int o, flit_t f);
    bit found;
    bit gen_waiting;
    bit nbr_waiting;
    found       = 1'b0;
    gen_waiting = exp_q[16 + o].size() > 0;
    nbr_waiting = 1'b0;
    for (int s = 0; s < 4; s++) begin
      nbr_waiting |= exp_q[s * 4 + o].size() > 0;
    end
    for (int s = 0; s < 5; s++) begin
      if (!found && exp_q[s * 4 + o].size() > 0 && exp_q[s * 4 + o][0] == f) begin
        void'(exp_q[s * 4 + o].pop_front());
        found = 1'b1;
        if (s == 4 && nbr_waiting) begin
          gen_shared++;
        end else if (s < 4 && gen_waiting && last_src[o] == 4) begin
          nbr_shared++;
        end
        last_src[o] = s;
      end
    end
    flits_seen++;
    if (!found) begin
      errors++;
      $display("Unexpected flit %h on output %0d at %0t, it matches no pending flit",
               f, o, $time);
    end
  endtask

  ////////////////////
  // Neighbours
  ////////////////////

  always @(negedge clk) begin
    for (int p = 0; p < 4; p++) begin
      take[p] = in_valid[p] && in_ready[p];
      if (rst_n && out_valid[p] && out_ready[p]) begin
        match_output(p, out_flit[p]);
      end
    end
  end

  always @(posedge clk) begin
    for (int p = 0; p < 4; p++) begin
      out_ready[p] <= (($random(seed) & 3) != 0);
      if (!rst_n) begin
        in_valid[p] <= 1'b0;
      end else if (!in_valid[p] || take[p]) begin
        if (drv_q[p].size() > 0 && (($random(seed) & 7) != 0)) begin
          in_flit[p]  <= drv_q[p].pop_front();
          in_valid[p] <= 1'b1;
        end else begin
          in_valid[p] <= 1'b0;
        end
      end
    end
  end

  task automatic queue_flit(int p, id_t dst);
    flit_t f;
    port_e o;
    f.hdr.dst_id = dst;
    f.hdr.src_id = rand_id();
    f.payload    = $random(seed);
    o            = route_of(dst);
    if (o == Eject) begin
      rx_count_model++;
      rx_xor_model ^= f.payload;
    end else begin
      exp_q[p * 4 + int'(o)].push_back(f);
    end
    drv_q[p].push_back(f);
  endtask

  task automatic wait_drain();
    while (pending() != 0) begin
      @(negedge clk);
    end
  endtask

  ////////////////////
  // Host port
  ////////////////////

  task automatic host_access(input logic we, input reg_addr_e addr, input logic [31:0] wdata,
                             output logic [31:0] rdata);
    @(posedge clk);
    host_req       <= '{we: we, addr: addr, wdata: wdata};
    host_req_valid <= 1'b1;
    @(negedge clk);
    check("host_ack_o before req", 32'(host_ack), 0);
    while (!host_ack) begin
      @(negedge clk);
    end
    rdata = host_rdata;
    @(posedge clk);
    host_req_valid <= 1'b0;
    @(negedge clk);
    check("host_ack_o after req drop", 32'(host_ack), 1);
    while (host_ack) begin
      @(negedge clk);
    end
  endtask

  task automatic reg_write(reg_addr_e addr, logic [31:0] data);
    logic [31:0] unused;
    host_access(1'b1, addr, data, unused);
  endtask

  task automatic reg_read(reg_addr_e addr, output logic [31:0] data);
    host_access(1'b0, addr, '0, data);
  endtask

  task automatic run_burst(id_t dst, int unsigned count, logic [31:0] start_val);
    logic [31:0] lfsr;
    logic [31:0] rd;
    flit_t       f;
    reg_write(RegDst, 32'(dst));
    reg_write(RegCount, count);
    reg_write(RegSeed, start_val);
    lfsr = start_val;
    for (int k = 0; k < int'(count); k++) begin
      f.hdr.dst_id = dst;
      f.hdr.src_id = TileId;
      f.payload    = lfsr;
      exp_q[16 + int'(route_of(dst))].push_back(f);
      lfsr = lfsr_step(lfsr);
    end
    reg_write(RegCtrl, 32'd1);
    rd = 32'd1;
    while (rd[0]) begin
      reg_read(RegStatus, rd);
    end
    reg_read(RegSent, rd);
    check("RegSent", rd, count);
  endtask

  task automatic check_rx();
    logic [31:0] rd;
    rd = '0;
    while (rd < rx_count_model) begin
      reg_read(RegRxCount, rd);
    end
    check("RegRxCount", rd, rx_count_model);
    reg_read(RegRxXor, rd);
    check("RegRxXor", rd, rx_xor_model);
  endtask

  ////////////////////
  // Test sequence
  ////////////////////

  initial begin
    logic [31:0] rd;
    logic [31:0] val;
    id_t         dst;
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check("valid_o", 32'(out_valid), 0);
    check("host_ack_o", 32'(host_ack), 0);
    reg_read(RegSent, rd);
    check("RegSent", rd, 0);
    reg_read(RegRxCount, rd);
    check("RegRxCount", rd, 0);
    reg_read(RegRxXor, rd);
    check("RegRxXor", rd, 0);
    reg_read(RegStatus, rd);
    check("RegStatus", rd, 0);
    reg_read(RegSeed, rd);
    check("RegSeed", rd, 1);
    reg_read(RegCount, rd);
    check("RegCount", rd, 0);

    // Only the low 6 bits of the destination read back
    val = $random(seed);
    reg_write(RegDst, val);
    reg_read(RegDst, rd);
    check("RegDst", rd, val & 32'h3f);
    val = $random(seed);
    reg_write(RegCount, val);
    reg_read(RegCount, rd);
    check("RegCount", rd, val);
    val = $random(seed);
    reg_write(RegSeed, val);
    reg_read(RegSeed, rd);
    check("RegSeed", rd, val);

    dst = rand_id();
    while (dst == TileId) begin
      dst = rand_id();
    end
    run_burst(dst, BurstLen, $random(seed) | 1);
    wait_drain();

    for (int i = 0; i < LocalFlits; i++) begin
      queue_flit($random(seed) & 3, TileId);
    end
    wait_drain();
    check_rx();

    for (int i = 0; i < TransitFlits; i++) begin
      dst = rand_id();
      while (dst == TileId) begin
        dst = rand_id();
      end
      queue_flit($random(seed) & 3, dst);
    end
    wait_drain();

    // Transit and burst share the East output
    for (int i = 0; i < MixFlits; i++) begin
      dst   = rand_id();
      dst.x = 3'd4 + 3'($random(seed) & 3);
      queue_flit($random(seed) & 3, dst);
    end
    dst   = rand_id();
    dst.x = 3'd4 + 3'($random(seed) & 3);
    run_burst(dst, BurstLen, $random(seed) | 1);
    wait_drain();
    if (gen_shared == 0 || nbr_shared == 0) begin
      errors++;
      $display("Burst and transit flits did not take turns on the shared East output");
    end
    check_rx();

    repeat (5) @(negedge clk);
    $display("Checked %0d flits, %0d errors", flits_seen, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

  initial begin
    #(LimitCycles * ClkPeriod);
    $display("Watchdog expired after %0d cycles, traffic or host port stalled", LimitCycles);
    $display("Errors found");
    $finish;
  end

endmodule

// File: tb.f
hw/noc_pkg.sv
hw/noc_router.sv
hw/noc_chimney.sv
hw/traffic_gen.sv
hw/traffic_gen_tile.sv
tb/tb_traffic_gen_tile.sv

// File: Makefile
# Verilator simulation of the traffic generator tile

TOP := tb_traffic_gen_tile

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench, fails unless it reports no errors"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f tb.f -o sim_$(TOP)
	@out="$$(./obj_dir/sim_$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "No errors"

clean:
	rm -rf obj_dir
